// ==== verif/dc_req_bridge_stimulus.txt ====
# Columns: op addr len id, all hex, then master stall cycles in decimal
# op 0 is a read and 1 is a write; the master side must see each request unchanged
1 00001000 00 01 0
0 00001004 03 02 1
1 8000fff0 ff 3f 0
0 12345678 07 00 2
1 deadbeec 0f 15 0
0 00000000 00 2a 3
1 fffffffc 80 3e 1
0 0badf00c 01 07 0
1 40000040 10 11 4
0 55aa55a8 20 22 0
1 aa55aa54 3f 33 1
0 00c0ffee 05 04 0
1 7ffffff0 40 2b 2
0 10203040 11 19 0
1 cafe0000 02 0a 0
0 00ff00ff fe 30 1
1 13579bdf 0c 3c 3
0 2468ace0 09 05 0
1 f0f0f0f0 1f 2f 2
0 0f0f0f0c 06 1e 0

// ==== src.f ====
+incdir+common
common/dc_pkg.sv
dc_fifo/dc_fifo_din.sv
dc_fifo/dc_fifo_slot.sv
dc_fifo/dc_fifo_dout.sv
logic/axi_single_slice.sv
logic/dc_req_bridge_top.sv
verif/dc_req_bridge_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the request bridge testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --timescale 1ns/100ps --top-module dc_req_bridge_tb \
	-f src.f -o dc_req_bridge_sim \
	&& ./obj_dir/dc_req_bridge_sim > sim.log 2>&1 \
	|| { echo "Build or simulation run failed"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q '^\*\*\* TEST PASSED \*\*\*$' sim.log && echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

// ==== verif/dc_req_bridge_tb.sv ====
`timescale 1ns/100ps

`include "dc_settings.svh"

module dc_req_bridge_tb
	import dc_pkg::*;
();

	logic slv_clk_i;
	logic clk_i;
	logic rst_n_i;
	axi_req_t slv_req_i;
	logic slv_valid_i;
	logic slv_ready_o;
	axi_req_t mst_req_o;
	logic mst_valid_o;
	logic mst_ready_i;

	axi_req_t stim_req[$];
	int stim_stall[$];
	axi_req_t expected_q[$];
	int slv_count;
	int mst_count;
	int mst_xfer_count;
	int mismatch_count;
	int error_count;
	int cycle_count;
	int cycle_limit = 0;
	int seed;
	logic stall_release;

	dc_req_bridge_top DUT (
		.slv_clk_i(slv_clk_i),
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.slv_req_i(slv_req_i),
		.slv_valid_i(slv_valid_i),
		.slv_ready_o(slv_ready_o),
		.mst_req_o(mst_req_o),
		.mst_valid_o(mst_valid_o),
		.mst_ready_i(mst_ready_i)
	);

	initial begin
		clk_i = 1'b0;
		forever begin
			#4 clk_i = ~clk_i;
		end
	end

	// Slave clock runs at 13 ns and is unrelated to the master clock
	initial begin
		slv_clk_i = 1'b0;
		forever begin
			#6.5 slv_clk_i = ~slv_clk_i;
		end
	end

	task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
		input string msg);
		if (actual !== expected) begin
			mismatch_count++;
			$display("Mismatch at %0t: %s, got %0h, expected %0h", $time, msg, actual, expected);
		end
	endtask

	task automatic load_stimulus();
		int fd;
		int fields;
		int stall_v;
		string line;
		logic [31:0] op_v;
		logic [31:0] addr_v;
		logic [31:0] len_v;
		logic [31:0] id_v;
		axi_req_t req;
		fd = $fopen("verif/dc_req_bridge_stimulus.txt", "r");
		if (fd == 0) begin
			error_count++;
			$display("Could not open the stimulus file");
			return;
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() > 1 && line.getc(0) != "#") begin
				fields = $sscanf(line, "%h %h %h %h %d", op_v, addr_v, len_v, id_v, stall_v);
				if (fields == 5) begin
					req.op = axi_op_e'(op_v[0]);
					req.addr = addr_v;
					req.len = len_v[`DC_LEN_WIDTH-1:0];
					req.id = id_v[`DC_ID_WIDTH-1:0];
					stim_req.push_back(req);
					stim_stall.push_back(stall_v);
				end
			end
		end
		$fclose(fd);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Slave side source
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic drive_slave();
		int waited;
		waited = 0;
		@(posedge slv_clk_i);
		#1;
		slv_req_i = stim_req[0];
		slv_valid_i = 1'b1;
		while (slv_count < stim_req.size()) begin
			@(posedge slv_clk_i);
			// The stall ends 20 slave cycles after the bridge should have filled up
			if (!stall_release && slv_count >= `DC_BUFFER_WIDTH) begin
				waited++;
				if (waited == 20) begin
					check_value(64'(slv_count), 64'(`DC_BUFFER_WIDTH),
						"requests accepted while stalled");
					check_value(64'(slv_ready_o), 64'd0, "slave ready after the stall");
					stall_release = 1'b1;
				end
			end
			if (slv_valid_i && slv_ready_o) begin
				expected_q.push_back(stim_req[slv_count]);
				slv_count++;
				#1;
				// Once the stall is over, valid drops for a cycle after every third request
				slv_valid_i = (slv_count < stim_req.size()) &&
					!(stall_release && slv_count % 3 == 0);
				if (slv_count < stim_req.size())
					slv_req_i = stim_req[slv_count];
			end else if (!slv_valid_i) begin
				#1;
				slv_valid_i = 1'b1;
			end
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Master side sink
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Counts every master handshake, also any that arrive after the sink is done
	always @(posedge clk_i) begin
		if (mst_valid_o && mst_ready_i) begin
			mst_xfer_count++;
		end
	end

	task automatic collect_master();
		int gap;
		axi_req_t exp_req;
		wait (stall_release);
		@(posedge clk_i);
		#1;
		mst_ready_i = 1'b1;
		while (mst_count < stim_req.size()) begin
			@(posedge clk_i);
			if (mst_valid_o && mst_ready_i) begin
				if (expected_q.size() == 0) begin
					error_count++;
					$display("Master side transfer at %0t with no request outstanding", $time);
				end else begin
					exp_req = expected_q.pop_front();
					check_value(64'(mst_req_o.op), 64'(exp_req.op),
						$sformatf("op of request %0d", mst_count));
					check_value(64'(mst_req_o.addr), 64'(exp_req.addr),
						$sformatf("addr of request %0d", mst_count));
					check_value(64'(mst_req_o.len), 64'(exp_req.len),
						$sformatf("len of request %0d", mst_count));
					check_value(64'(mst_req_o.id), 64'(exp_req.id),
						$sformatf("id of request %0d", mst_count));
				end
				gap = stim_stall[mst_count] + int'({$random(seed)} % 3);
				mst_count++;
				if (gap > 0) begin
					#1;
					mst_ready_i = 1'b0;
					repeat (gap) @(posedge clk_i);
					#1;
					mst_ready_i = 1'b1;
				end
			end
		end
	endtask

	initial begin
		cycle_count = 0;
		wait (cycle_limit > 0);
		while (cycle_count < cycle_limit) begin
			@(posedge clk_i);
			cycle_count++;
		end
		$display("Timeout after %0d clock cycles, requests stopped moving", cycle_count);
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin
		rst_n_i = 1'b0;
		slv_req_i = '0;
		slv_valid_i = 1'b0;
		mst_ready_i = 1'b0;
		stall_release = 1'b0;
		seed = 32'h6458_2a8f;
		slv_count = 0;
		mst_count = 0;
		mst_xfer_count = 0;
		mismatch_count = 0;
		error_count = 0;
		load_stimulus();
		if (stim_req.size() <= `DC_BUFFER_WIDTH) begin
			$display("Stimulus file is missing or too short for the stall test");
			$display("*** TEST FAILED ***");
			$finish;
		end
		cycle_limit = 40 * stim_req.size() + 200;
		repeat (2) @(posedge clk_i);
		#1;
		rst_n_i = 1'b1;
		@(posedge clk_i);
		check_value(64'(mst_valid_o), 64'd0, "master valid after reset");
		check_value(64'(slv_ready_o), 64'd1, "slave ready after reset");
		fork
			drive_slave();
			collect_master();
		join
		repeat (10) @(posedge clk_i);
		check_value(64'(mst_valid_o), 64'd0, "master valid after the last request");
		check_value(64'(mst_xfer_count), 64'(slv_count),
			"master transfers against slave transfers");
		check_value(64'(expected_q.size()), 64'd0, "requests still outstanding");
		$display("Errors: %0d mismatches, %0d other failures", mismatch_count, error_count);
		if (mismatch_count == 0 && error_count == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// ==== logic/dc_req_bridge_top.sv ====
`timescale 1ns/100ps

`include "dc_settings.svh"

module dc_req_bridge_top
	import dc_pkg::*;
(
	input logic slv_clk_i,
	input logic clk_i,
	input logic rst_n_i,
	input axi_req_t slv_req_i,
	input logic slv_valid_i,
	output logic slv_ready_o,
	output axi_req_t mst_req_o,
	output logic mst_valid_o,
	input logic mst_ready_i
);

	logic [`DC_BUFFER_WIDTH-1:0] write_token;
	logic [`DC_BUFFER_WIDTH-1:0] read_ptr;
	logic [`DC_BUFFER_WIDTH-1:0] slot_we;
	axi_req_t slot_req;
	req_slots_t slots;
	axi_req_t fifo_req;
	logic fifo_valid;
	logic fifo_ready;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Slave clock domain
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	dc_fifo_din u_din (
		.slv_clk_i(slv_clk_i),
		.rst_n_i(rst_n_i),
		.req_i(slv_req_i),
		.valid_i(slv_valid_i),
		.ready_o(slv_ready_o),
		.read_ptr_i(read_ptr),
		.write_token_o(write_token),
		.slot_we_o(slot_we),
		.req_o(slot_req)
	);

	for (genvar i = 0; i < `DC_BUFFER_WIDTH; i++) begin : g_slot
		dc_fifo_slot u_slot (
			.slv_clk_i(slv_clk_i),
			.rst_n_i(rst_n_i),
			.we_i(slot_we[i]),
			.req_i(slot_req),
			.req_o(slots[i])
		);
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Master clock domain
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	dc_fifo_dout u_dout (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.write_token_i(write_token),
		.slots_i(slots),
		.read_ptr_o(read_ptr),
		.req_o(fifo_req),
		.valid_o(fifo_valid),
		.ready_i(fifo_ready)
	);

	axi_single_slice u_slice (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.req_i(fifo_req),
		.valid_i(fifo_valid),
		.ready_o(fifo_ready),
		.req_o(mst_req_o),
		.valid_o(mst_valid_o),
		.ready_i(mst_ready_i)
	);

endmodule

// ==== logic/axi_single_slice.sv ====
`timescale 1ns/100ps

module axi_single_slice
	import dc_pkg::*;
(
	input logic clk_i,
	input logic rst_n_i,
	input axi_req_t req_i,
	input logic valid_i,
	output logic ready_o,
	output axi_req_t req_o,
	output logic valid_o,
	input logic ready_i
);

	typedef enum logic {
		SLICE_EMPTY,
		SLICE_FULL
	} slice_state_e;

	slice_state_e state_q;
	axi_req_t req_q;
	logic load;

	// Downstream ready may pop the reader while only its registered pointer crosses clocks
	assign ready_o = (state_q == SLICE_EMPTY) | ready_i;
	assign load = valid_i & ready_o;

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q <= SLICE_EMPTY;
		end else if (load) begin
			state_q <= SLICE_FULL;
		end else if (ready_i) begin
			state_q <= SLICE_EMPTY;
		end
	end

	always_ff @(posedge clk_i) begin
		if (load) begin
			req_q <= req_i;
		end
	end

	assign valid_o = (state_q == SLICE_FULL);
	assign req_o = req_q;

endmodule

// ==== dc_fifo/dc_fifo_dout.sv ====
`timescale 1ns/100ps

`include "dc_settings.svh"

module dc_fifo_dout
	import dc_pkg::*;
(
	input logic clk_i,
	input logic rst_n_i,
	input logic [`DC_BUFFER_WIDTH-1:0] write_token_i,
	input req_slots_t slots_i,
	output logic [`DC_BUFFER_WIDTH-1:0] read_ptr_o,
	output axi_req_t req_o,
	output logic valid_o,
	input logic ready_i
);

	logic [`DC_BUFFER_WIDTH-1:0] write_token_meta;
	logic [`DC_BUFFER_WIDTH-1:0] write_token_sync;
	logic [`DC_BUFFER_WIDTH-1:0] read_ptr;
	logic [`DC_BUFFER_WIDTH-1:0] ptr_next;
	logic empty;
	logic pop;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Write token crossing
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			write_token_meta <= `DC_BUFFER_WIDTH'(1);
			write_token_sync <= `DC_BUFFER_WIDTH'(1);
		end else begin
			write_token_meta <= write_token_i;
			write_token_sync <= write_token_meta;
		end
	end

	assign empty = (write_token_sync == read_ptr);
	assign valid_o = ~empty;
	assign pop = valid_o & ready_i;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Read pointer and slot select
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign ptr_next = {read_ptr[`DC_BUFFER_WIDTH-2:0], read_ptr[`DC_BUFFER_WIDTH-1]};

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			read_ptr <= `DC_BUFFER_WIDTH'(1);
		end else if (pop) begin
			read_ptr <= ptr_next;
		end
	end

	// AND-OR mux, the pointer is one-hot so exactly one slot passes
	always_comb begin
		req_o = '0;
		for (int i = 0; i < `DC_BUFFER_WIDTH; i++) begin
			if (read_ptr[i]) begin
				req_o = req_o | slots_i[i];
			end
		end
	end

	assign read_ptr_o = read_ptr;

endmodule

// ==== dc_fifo/dc_fifo_slot.sv ====
`timescale 1ns/100ps

module dc_fifo_slot
	import dc_pkg::*;
(
	input logic slv_clk_i,
	input logic rst_n_i,
	input logic we_i,
	input axi_req_t req_i,
	output axi_req_t req_o
);

	axi_req_t slot_q;

	// Written in the slave domain, read from the master domain only once
	// the write token has crossed over, so the value is stable by then
	always_ff @(posedge slv_clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			slot_q <= '0;
		end else if (we_i) begin
			slot_q <= req_i;
		end
	end

	assign req_o = slot_q;

endmodule

// ==== dc_fifo/dc_fifo_din.sv ====
`timescale 1ns/100ps

`include "dc_settings.svh"

module dc_fifo_din
	import dc_pkg::*;
(
	input logic slv_clk_i,
	input logic rst_n_i,
	input axi_req_t req_i,
	input logic valid_i,
	output logic ready_o,
	input logic [`DC_BUFFER_WIDTH-1:0] read_ptr_i,
	output logic [`DC_BUFFER_WIDTH-1:0] write_token_o,
	output logic [`DC_BUFFER_WIDTH-1:0] slot_we_o,
	output axi_req_t req_o
);

	logic [`DC_BUFFER_WIDTH-1:0] write_token;
	logic [`DC_BUFFER_WIDTH-1:0] token_next;
	logic [`DC_BUFFER_WIDTH-1:0] read_ptr_meta;
	logic [`DC_BUFFER_WIDTH-1:0] read_ptr_sync;
	logic full;
	logic push;

	// Two-flop synchronizer for the reader's pointer
	always_ff @(posedge slv_clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			read_ptr_meta <= `DC_BUFFER_WIDTH'(1);
			read_ptr_sync <= `DC_BUFFER_WIDTH'(1);
		end else begin
			read_ptr_meta <= read_ptr_i;
			read_ptr_sync <= read_ptr_meta;
		end
	end

	assign token_next = {write_token[`DC_BUFFER_WIDTH-2:0], write_token[`DC_BUFFER_WIDTH-1]};

	// One slot always stays free so that full and empty can be told apart
	assign full = (token_next == read_ptr_sync);
	assign ready_o = ~full;
	assign push = valid_i & ~full;

	always_ff @(posedge slv_clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			write_token <= `DC_BUFFER_WIDTH'(1);
		end else if (push) begin
			write_token <= token_next;
		end
	end

	assign slot_we_o = write_token & {`DC_BUFFER_WIDTH{push}};
	assign write_token_o = write_token;

	// Every slot sees the same data, only its enable differs
	assign req_o = req_i;

endmodule

// ==== common/dc_pkg.sv ====
`include "dc_settings.svh"

package dc_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Request channel types
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef enum logic {
		OP_READ = 1'b0,
		OP_WRITE = 1'b1
	} axi_op_e;

	// 47 bits with the default widths
	typedef struct packed {
		axi_op_e op;
		logic [`DC_ADDR_WIDTH-1:0] addr;
		logic [`DC_LEN_WIDTH-1:0] len;
		logic [`DC_ID_WIDTH-1:0] id;
	} axi_req_t;

	// Stored value of every slot, as seen by the reader
	typedef axi_req_t [`DC_BUFFER_WIDTH-1:0] req_slots_t;

endpackage

// ==== common/dc_settings.svh ====
`ifndef DC_SETTINGS_SVH
`define DC_SETTINGS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Clock crossing FIFO
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Number of slots, also the width of the one-hot token and pointer
`define DC_BUFFER_WIDTH 8

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Request fields
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define DC_ADDR_WIDTH 32
`define DC_LEN_WIDTH 8
`define DC_ID_WIDTH 6

`endif
